//--- logic/frontend_consts.svh
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// first fetch address out of reset
`define FE_RESET_PC     32'h1c00_0000

// instruction queue entries, split over two banks
`define FE_QUEUE_DEPTH  8

// register usage classes
`define REG_TYPE_I      4'd0
`define REG_TYPE_RW     4'd1
`define REG_TYPE_RRW    4'd2
`define REG_TYPE_RR     4'd3
`define REG_TYPE_BL     4'd4
`define REG_TYPE_W      4'd5

`endif

//--- logic/frontend_pkg.sv
package frontend_pkg;

    // fetch and instruction addresses
    typedef logic [31:0] addr_t;

    typedef logic [31:0] inst_word_t;

    // one fetch pair, lane 0 in the low half
    typedef logic [63:0] pair_t;

    typedef logic [4:0] reg_num_t;

    // one of the REG_TYPE codes
    typedef logic [3:0] reg_type_t;

    // fetch unit bus sequencing
    typedef enum logic [1:0] {
        IDLE,
        WAIT_RESP,
        HOLD,
        DROP
    } fetch_state_t;

endpackage

//--- logic/npc.sv
`timescale 1ns/100ps
`include "frontend_consts.svh"

module npc (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                stall_i,
    input  logic                flush_i,
    input  frontend_pkg::addr_t redirect_pc_i,
    output frontend_pkg::addr_t pc_o,
    output logic [1:0]          lane_mask_o
);
    import frontend_pkg::*;

    addr_t pc_q;
    addr_t pc_step;

    // next pair boundary, any odd-word offset is dropped
    assign pc_step = {pc_q[31:3] + 29'd1, 3'b000};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= `FE_RESET_PC;
        end else if (flush_i) begin
            // keep the word offset so lane 0 can be skipped
            pc_q <= {redirect_pc_i[31:2], 2'b00};
        end else if (!stall_i) begin
            pc_q <= pc_step;
        end
    end

    assign pc_o = pc_q;

    // upper lane always wanted, lower one only for an even-word pc
    assign lane_mask_o = {1'b1, ~pc_q[2]};

    // stepping and redirect both keep the pc word aligned
    assert property (@(posedge clk) disable iff (!rst_n_i)
        pc_o[1:0] == 2'b00);

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  frontend_pkg::addr_t      pc_i,
    input  logic [1:0]               lane_mask_i,
    input  logic                     bus_resp_valid_i,
    input  frontend_pkg::pair_t      bus_resp_data_i,
    input  logic                     queue_ready_i,
    output logic                     accept_o,
    output logic                     bus_req_valid_o,
    output frontend_pkg::addr_t      bus_req_addr_o,
    output frontend_pkg::inst_word_t word_o [2],
    output frontend_pkg::addr_t      pc_o [2],
    output logic [1:0]               write_num_o
);
    import frontend_pkg::*;

    fetch_state_t state_q;
    fetch_state_t state_d;
    addr_t        req_addr_q;
    logic [1:0]   mask_q;
    pair_t        pair_q;
    logic         holding;

    assign holding = (state_q == HOLD);

    // take a pc when idle, or when the held pair drains this cycle
    assign accept_o = !flush_i && ((state_q == IDLE) || (holding && queue_ready_i));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept_o) begin
                    state_d = WAIT_RESP;
                end
            end
            WAIT_RESP: begin
                if (bus_resp_valid_i) begin
                    state_d = flush_i ? IDLE : HOLD;
                end else if (flush_i) begin
                    state_d = DROP;
                end
            end
            HOLD: begin
                if (flush_i) begin
                    state_d = IDLE;
                end else if (accept_o) begin
                    state_d = WAIT_RESP;
                end
            end
            DROP: begin
                // stale response still owed by the bus
                if (bus_resp_valid_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_o) begin
            req_addr_q <= {pc_i[31:3], 3'b000};
            mask_q     <= lane_mask_i;
        end
        if (state_q == WAIT_RESP && bus_resp_valid_i) begin
            pair_q <= bus_resp_data_i;
        end
    end

    assign bus_req_valid_o = (state_q == WAIT_RESP) || (state_q == DROP);
    assign bus_req_addr_o  = req_addr_q;

    // a lone upper word moves down to lane 0
    assign word_o[0] = mask_q[0] ? pair_q[31:0] : pair_q[63:32];
    assign word_o[1] = pair_q[63:32];
    assign pc_o[0]   = {req_addr_q[31:3], ~mask_q[0], 2'b00};
    assign pc_o[1]   = {req_addr_q[31:3], 3'b100};

    assign write_num_o = holding ? {mask_q[0] & mask_q[1], mask_q[0] ^ mask_q[1]} : 2'd0;

    // bus request is a level with a fixed address until answered
    assert property (@(posedge clk) disable iff (!rst_n_i)
        bus_req_valid_o && !bus_resp_valid_i |=> bus_req_valid_o && $stable(bus_req_addr_o));

endmodule

//--- logic/multi_channel_fifo.sv
`timescale 1ns/100ps

module multi_channel_fifo #(
    parameter int DATA_WIDTH = 64,
    parameter int DEPTH      = 8
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic [1:0]            write_num_i,
    input  logic [DATA_WIDTH-1:0] write_data_i [2],
    output logic                  write_ready_o,
    output logic [1:0]            read_valid_o,
    input  logic                  read_ready_i,
    input  logic [1:0]            read_num_i,
    output logic [DATA_WIDTH-1:0] read_data_o [2]
);
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int BANK_D = DEPTH / 2;

    logic [DATA_WIDTH-1:0] bank_mem [2][BANK_D];
    logic [PTR_W-1:0]      head_q;
    logic [PTR_W-1:0]      tail_q;
    logic [CNT_W-1:0]      count_q;
    logic [1:0]            wr_num;
    logic [1:0]            rd_num;
    logic [PTR_W-1:0]      wr_ptr [2];
    logic [PTR_W-1:0]      rd_ptr [2];

    // room for a full pair
    assign write_ready_o = (count_q <= CNT_W'(DEPTH - 2));

    assign wr_num = write_ready_o ? write_num_i : 2'd0;
    assign rd_num = read_ready_i ? read_num_i : 2'd0;

    assign wr_ptr[0] = tail_q;
    assign wr_ptr[1] = tail_q + PTR_W'(1);
    assign rd_ptr[0] = head_q;
    assign rd_ptr[1] = head_q + PTR_W'(1);

    // pointer bit 0 picks the bank, so neighbours never share one
    always_ff @(posedge clk) begin
        if (wr_num != 2'd0) begin
            bank_mem[wr_ptr[0][0]][wr_ptr[0][PTR_W-1:1]] <= write_data_i[0];
        end
        if (wr_num == 2'd2) begin
            bank_mem[wr_ptr[1][0]][wr_ptr[1][PTR_W-1:1]] <= write_data_i[1];
        end
    end

    assign read_data_o[0] = bank_mem[rd_ptr[0][0]][rd_ptr[0][PTR_W-1:1]];
    assign read_data_o[1] = bank_mem[rd_ptr[1][0]][rd_ptr[1][PTR_W-1:1]];

    assign read_valid_o = {count_q >= CNT_W'(2), count_q != '0};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + PTR_W'(rd_num);
            tail_q  <= tail_q + PTR_W'(wr_num);
            count_q <= count_q + CNT_W'(wr_num) - CNT_W'(rd_num);
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        count_q <= CNT_W'(DEPTH));

    // backend must not take more than is shown valid
    assert property (@(posedge clk) disable iff (!rst_n_i)
        read_ready_i && !flush_i |-> CNT_W'(read_num_i) <= count_q);

endmodule

//--- logic/decoder.sv
`timescale 1ns/100ps
`include "frontend_consts.svh"

module decoder (
    input  frontend_pkg::inst_word_t inst_i,
    output frontend_pkg::reg_type_t  reg_type_o,
    output frontend_pkg::reg_num_t   rj_o,
    output frontend_pkg::reg_num_t   rk_o,
    output frontend_pkg::reg_num_t   rd_o
);
    import frontend_pkg::*;

    logic [5:0] opcode;

    assign opcode = inst_i[31:26];

    // class from the major opcode
    always_comb begin
        case (opcode)
            6'h00:   reg_type_o = inst_i[25] ? `REG_TYPE_RRW : `REG_TYPE_RW;
            6'h15:   reg_type_o = `REG_TYPE_BL;
            6'h16:   reg_type_o = `REG_TYPE_RR;
            6'h17:   reg_type_o = `REG_TYPE_RR;
            6'h0a:   reg_type_o = `REG_TYPE_W;
            default: reg_type_o = `REG_TYPE_I;
        endcase
    end

    // unused fields read as r0
    always_comb begin
        case (reg_type_o)
            `REG_TYPE_RRW: begin
                rj_o = inst_i[9:5];
                rk_o = inst_i[14:10];
                rd_o = inst_i[4:0];
            end
            `REG_TYPE_RW: begin
                rj_o = inst_i[9:5];
                rk_o = '0;
                rd_o = inst_i[4:0];
            end
            `REG_TYPE_W: begin
                rj_o = '0;
                rk_o = '0;
                rd_o = inst_i[4:0];
            end
            `REG_TYPE_RR: begin
                // branch compares take rd as second source
                rj_o = inst_i[9:5];
                rk_o = inst_i[4:0];
                rd_o = '0;
            end
            `REG_TYPE_BL: begin
                rj_o = '0;
                rk_o = '0;
                rd_o = reg_num_t'(1);
            end
            default: begin
                rj_o = '0;
                rk_o = '0;
                rd_o = '0;
            end
        endcase
    end

endmodule

//--- logic/frontend.sv
`timescale 1ns/100ps
`include "frontend_consts.svh"

module frontend (
    input  logic                     clk,
    input  logic                     rst_n_i,

    // memory bus
    output logic                     bus_req_valid_o,
    output frontend_pkg::addr_t      bus_req_addr_o,
    input  logic                     bus_resp_valid_i,
    input  frontend_pkg::pair_t      bus_resp_data_i,

    // issue side
    output logic [1:0]               inst_valid_o,
    output frontend_pkg::addr_t      inst_pc_o [2],
    output frontend_pkg::inst_word_t inst_word_o [2],
    output frontend_pkg::reg_type_t  inst_reg_type_o [2],
    output frontend_pkg::reg_num_t   inst_rj_o [2],
    output frontend_pkg::reg_num_t   inst_rk_o [2],
    output frontend_pkg::reg_num_t   inst_rd_o [2],
    input  logic [1:0]               issue_num_i,
    input  logic                     backend_stall_i,

    // redirect
    input  logic                     flush_i,
    input  frontend_pkg::addr_t      redirect_pc_i
);
    import frontend_pkg::*;

    // queue entry is pc over word
    localparam int QUEUE_WIDTH = $bits(addr_t) + $bits(inst_word_t);

    addr_t                  npc_pc;
    logic [1:0]             npc_lane_mask;
    logic                   fetch_accept;
    inst_word_t             fetch_word [2];
    addr_t                  fetch_pc [2];
    logic [1:0]             fetch_write_num;
    logic                   queue_ready;
    logic [QUEUE_WIDTH-1:0] queue_wdata [2];
    logic [QUEUE_WIDTH-1:0] queue_rdata [2];

    npc u_npc (
        .clk,
        .rst_n_i,
        .stall_i       (!fetch_accept),
        .flush_i,
        .redirect_pc_i,
        .pc_o          (npc_pc),
        .lane_mask_o   (npc_lane_mask)
    );

    fetch_unit u_fetch (
        .clk,
        .rst_n_i,
        .flush_i,
        .pc_i             (npc_pc),
        .lane_mask_i      (npc_lane_mask),
        .bus_resp_valid_i,
        .bus_resp_data_i,
        .queue_ready_i    (queue_ready),
        .accept_o         (fetch_accept),
        .bus_req_valid_o,
        .bus_req_addr_o,
        .word_o           (fetch_word),
        .pc_o             (fetch_pc),
        .write_num_o      (fetch_write_num)
    );

    multi_channel_fifo #(
        .DATA_WIDTH (QUEUE_WIDTH),
        .DEPTH      (`FE_QUEUE_DEPTH)
    ) u_queue (
        .clk,
        .rst_n_i,
        .flush_i,
        .write_num_i   (fetch_write_num),
        .write_data_i  (queue_wdata),
        .write_ready_o (queue_ready),
        .read_valid_o  (inst_valid_o),
        .read_ready_i  (!backend_stall_i),
        .read_num_i    (issue_num_i),
        .read_data_o   (queue_rdata)
    );

    for (genvar i = 0; i < 2; i++) begin : g_lane
        assign queue_wdata[i] = {fetch_pc[i], fetch_word[i]};
        assign inst_pc_o[i]   = queue_rdata[i][QUEUE_WIDTH-1:32];
        assign inst_word_o[i] = queue_rdata[i][31:0];

        decoder u_decoder (
            .inst_i     (inst_word_o[i]),
            .reg_type_o (inst_reg_type_o[i]),
            .rj_o       (inst_rj_o[i]),
            .rk_o       (inst_rk_o[i]),
            .rd_o       (inst_rd_o[i])
        );
    end

endmodule

//--- bench/tb_frontend.sv
`timescale 1ns/100ps
`include "frontend_consts.svh"

module tb_frontend;
    import frontend_pkg::*;

    localparam addr_t RESET_PC     = `FE_RESET_PC;
    localparam int    N_ISSUE      = 300;
    localparam int    BASE_CYCLES  = 2000;
    localparam int    FLUSH_CYCLES = 20;

    logic       clk;
    logic       rst_n_i;
    logic       bus_req_valid_o;
    addr_t      bus_req_addr_o;
    logic       bus_resp_valid_i;
    pair_t      bus_resp_data_i;
    logic [1:0] inst_valid_o;
    addr_t      inst_pc_o [2];
    inst_word_t inst_word_o [2];
    reg_type_t  inst_reg_type_o [2];
    reg_num_t   inst_rj_o [2];
    reg_num_t   inst_rk_o [2];
    reg_num_t   inst_rd_o [2];
    logic [1:0] issue_num_i;
    logic       backend_stall_i;
    logic       flush_i;
    addr_t      redirect_pc_i;

    inst_word_t  mem [64];
    logic [15:0] lfsr_q;
    addr_t       exp_pc;
    addr_t       req_addr;
    logic        pending;
    int          bus_wait;
    int          stall_left;
    int          issued;
    int          flush_count;
    int          value_errors;
    int          other_errors;

    frontend DUT (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .bus_req_valid_o  (bus_req_valid_o),
        .bus_req_addr_o   (bus_req_addr_o),
        .bus_resp_valid_i (bus_resp_valid_i),
        .bus_resp_data_i  (bus_resp_data_i),
        .inst_valid_o     (inst_valid_o),
        .inst_pc_o        (inst_pc_o),
        .inst_word_o      (inst_word_o),
        .inst_reg_type_o  (inst_reg_type_o),
        .inst_rj_o        (inst_rj_o),
        .inst_rk_o        (inst_rk_o),
        .inst_rd_o        (inst_rd_o),
        .issue_num_i      (issue_num_i),
        .backend_stall_i  (backend_stall_i),
        .flush_i          (flush_i),
        .redirect_pc_i    (redirect_pc_i)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // bias the major opcode towards the classes the decoder knows
    function inst_word_t make_word();
        logic [31:0] sel;
        logic [31:0] low;
        logic [5:0]  op;
        sel = rand_bits(3);
        low = rand_bits(26);
        case (sel[2:0])
            3'd2:    op = 6'h15;
            3'd3:    op = 6'h16;
            3'd4:    op = 6'h17;
            3'd5:    op = 6'h0a;
            3'd6:    op = 6'h03;
            3'd7:    op = 6'h2b;
            default: op = 6'h00;
        endcase
        return {op, low[25:0]};
    endfunction

    function reg_type_t model_type(input inst_word_t w);
        if (w[31:26] == 6'h00) begin
            return w[25] ? `REG_TYPE_RRW : `REG_TYPE_RW;
        end
        if (w[31:26] == 6'h15) begin
            return `REG_TYPE_BL;
        end
        if (w[31:26] == 6'h16 || w[31:26] == 6'h17) begin
            return `REG_TYPE_RR;
        end
        if (w[31:26] == 6'h0a) begin
            return `REG_TYPE_W;
        end
        return `REG_TYPE_I;
    endfunction

    task check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task check_word(input string name, input inst_word_t got, input inst_word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task check_reg(input string name, input reg_num_t got, input reg_num_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task check_type(input string name, input reg_type_t got, input reg_type_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task check_idle_outputs(input string when);
        if (bus_req_valid_o !== 1'b0 || inst_valid_o !== 2'b00) begin
            other_errors++;
            $display("bus request or instruction valid is raised %s", when);
        end
    endtask

    // one lane about to leave the queue checked against the model
    task check_lane(input int i);
        inst_word_t w;
        reg_type_t  t;
        reg_num_t   rj;
        reg_num_t   rk;
        reg_num_t   rd;
        w = mem[exp_pc[7:2]];
        t = model_type(w);
        rj = (t == `REG_TYPE_RRW || t == `REG_TYPE_RW || t == `REG_TYPE_RR) ? w[9:5] : 5'd0;
        rk = (t == `REG_TYPE_RRW) ? w[14:10] : (t == `REG_TYPE_RR) ? w[4:0] : 5'd0;
        rd = (t == `REG_TYPE_RRW || t == `REG_TYPE_RW || t == `REG_TYPE_W) ? w[4:0] :
             (t == `REG_TYPE_BL) ? 5'd1 : 5'd0;
        check_addr($sformatf("inst_pc_o[%0d]", i), inst_pc_o[i], exp_pc);
        check_word($sformatf("inst_word_o[%0d]", i), inst_word_o[i], w);
        check_type($sformatf("inst_reg_type_o[%0d]", i), inst_reg_type_o[i], t);
        check_reg($sformatf("inst_rj_o[%0d]", i), inst_rj_o[i], rj);
        check_reg($sformatf("inst_rk_o[%0d]", i), inst_rk_o[i], rk);
        check_reg($sformatf("inst_rd_o[%0d]", i), inst_rd_o[i], rd);
        exp_pc = exp_pc + 32'd4;
        issued++;
    endtask

    // memory with 1 to 4 cycles of latency and one request at a time
    task drive_bus();
        logic [31:0] r;
        bus_resp_valid_i = 1'b0;
        if (pending) begin
            if (bus_req_valid_o !== 1'b1) begin
                other_errors++;
                $display("bus request dropped before its response");
            end
            check_addr("bus_req_addr_o", bus_req_addr_o, req_addr);
            bus_wait--;
            if (bus_wait == 0) begin
                bus_resp_valid_i = 1'b1;
                bus_resp_data_i  = {mem[{req_addr[7:3], 1'b1}], mem[{req_addr[7:3], 1'b0}]};
                pending = 1'b0;
            end
        end else if (bus_req_valid_o) begin
            r = rand_bits(2);
            pending  = 1'b1;
            req_addr = bus_req_addr_o;
            bus_wait = 1 + int'(r);
        end
    endtask

    task drive_backend();
        logic [31:0] r;
        logic [1:0]  valid_cnt;
        logic [1:0]  n;
        logic        stall;
        valid_cnt = {1'b0, inst_valid_o[0]} + {1'b0, inst_valid_o[1]};
        if (inst_valid_o === 2'b10) begin
            other_errors++;
            $display("lane 1 is valid while lane 0 is empty");
        end
        if (stall_left != 0) begin
            stall = 1'b1;
            stall_left--;
        end else begin
            r = rand_bits(5);
            if (r == 0) begin
                // long stall so the queue fills up
                r = rand_bits(4);
                stall_left = 6 + int'(r);
                stall = 1'b1;
            end else begin
                r = rand_bits(2);
                stall = (r == 0);
            end
        end
        backend_stall_i = stall;
        r = rand_bits(6);
        if (r == 0 && issued != 0) begin
            r = rand_bits(6);
            redirect_pc_i = {RESET_PC[31:8], r[5:0], 2'b00};
            flush_i       = 1'b1;
            issue_num_i   = 2'd0;
            exp_pc        = redirect_pc_i;
            flush_count++;
        end else begin
            flush_i = 1'b0;
            // a count offered under stall must not drain the queue
            r = rand_bits(2);
            n = (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
            if (n > valid_cnt) begin
                n = valid_cnt;
            end
            if (!stall) begin
                for (int i = 0; i < int'(n); i++) begin
                    check_lane(i);
                end
            end
            issue_num_i = n;
        end
    endtask

    initial begin : stimulus
        rst_n_i          = 1'b0;
        bus_resp_valid_i = 1'b0;
        bus_resp_data_i  = '0;
        issue_num_i      = 2'd0;
        backend_stall_i  = 1'b0;
        flush_i          = 1'b0;
        redirect_pc_i    = '0;
        lfsr_q           = 16'd21;
        exp_pc           = RESET_PC;
        pending          = 1'b0;
        bus_wait         = 0;
        stall_left       = 0;
        issued           = 0;
        flush_count      = 0;
        value_errors     = 0;
        other_errors     = 0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = make_word();
        end
        repeat (2) @(posedge clk);
        #10;
        check_idle_outputs("during reset");
        repeat (14) @(posedge clk);
        #10;
        check_idle_outputs("at reset release");
        rst_n_i = 1'b1;
        while (issued < N_ISSUE) begin
            @(posedge clk);
            #10;
            drive_bus();
            drive_backend();
        end
        $display("value errors: %0d, other errors: %0d, issued: %0d, flushes: %0d",
                 value_errors, other_errors, issued, flush_count);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // limit grows with every redirect
    initial begin : watchdog
        int waited;
        waited = 0;
        while (waited < BASE_CYCLES + FLUSH_CYCLES * flush_count) begin
            @(posedge clk);
            waited++;
        end
        $display("timeout after %0d cycles with %0d instructions issued", waited, issued);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- src.f
+incdir+logic
logic/frontend_pkg.sv
logic/npc.sv
logic/fetch_unit.sv
logic/multi_channel_fifo.sv
logic/decoder.sv
logic/frontend.sv
bench/tb_frontend.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_frontend \
    -o tb_frontend_sim

out=$(./obj_dir/tb_frontend_sim)
echo "$out"

if grep -qx "All checks passed" <<< "$out"; then
    exit 0
fi
exit 1
